// File: hdl/sha512_afu.sv
`timescale 1ns/1ps

module sha512_afu
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  sha512_pkg::t_host_rx host_rx,
  output sha512_pkg::t_host_tx host_tx
);

  // ====================================================================
  // Host input register
  // ====================================================================

  // Every host input lands here first, so the blocks see it a cycle late
  sha512_pkg::t_host_rx host_rx_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      host_rx_q <= '0;
    else
      host_rx_q <= host_rx;
  end

  // ====================================================================
  // Blocks
  // ====================================================================
  sha512_pkg::t_ctrl ctrl;
  logic              job_done;
  logic              fold_clear;
  logic              fold_valid;
  sha512_pkg::t_word fold_word;
  sha512_pkg::t_word digest;

  // The outgoing channels come straight from block registers
  sha512_csr u_csr
  (
    .clk      (clk),
    .arst_n   (arst_n),
    .mmio_req (host_rx_q.mmio_req),
    .mmio_rsp (host_tx.mmio_rsp),
    .ctrl     (ctrl),
    .job_done (job_done)
  );

  sha512_requestor u_requestor
  (
    .clk        (clk),
    .arst_n     (arst_n),
    .ctrl       (ctrl),
    .rd_rsp     (host_rx_q.rd_rsp),
    .rd_credit  (host_rx_q.rd_credit),
    .wr_credit  (host_rx_q.wr_credit),
    .rd_req     (host_tx.rd_req),
    .wr_req     (host_tx.wr_req),
    .fold_clear (fold_clear),
    .fold_valid (fold_valid),
    .fold_word  (fold_word),
    .digest     (digest),
    .job_done   (job_done)
  );

  sha512_sigma_fold u_fold
  (
    .clk    (clk),
    .arst_n (arst_n),
    .clear  (fold_clear),
    .valid  (fold_valid),
    .word   (fold_word),
    .digest (digest)
  );

endmodule

// File: hdl/sha512_cfg.svh
`ifndef SHA512_CFG_SVH
`define SHA512_CFG_SVH

// ====================================================================
// Credit pools handed to the requestor out of reset
// ====================================================================
`define SHA512_RD_CREDITS 4
`define SHA512_WR_CREDITS 2

// Widths of the word, address and length fields
`define SHA512_WORD_W 64
`define SHA512_ADDR_W 32
`define SHA512_LEN_W 16

// MMIO register indices as seen on the 3-bit index field
`define SHA512_REG_CTRL 3'd0
`define SHA512_REG_DSM 3'd1
`define SHA512_REG_SRC 3'd2
`define SHA512_REG_LEN 3'd3
`define SHA512_REG_STAT 3'd4

// First SHA-512 initial hash word, the starting value of every digest
`define SHA512_IV 64'h6a09e667f3bcc908

`endif

// File: hdl/sha512_csr.sv
`timescale 1ns/1ps
`include "sha512_cfg.svh"

module sha512_csr
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  sha512_pkg::t_mmio_req mmio_req,
  output sha512_pkg::t_mmio_rsp mmio_rsp,
  output sha512_pkg::t_ctrl     ctrl,
  input  logic                  job_done
);

  // Job setup registers, loaded only by host writes
  sha512_pkg::t_addr dsm_q;
  sha512_pkg::t_addr src_q;
  sha512_pkg::t_len  len_q;

  logic              start_q;
  logic              done_q;
  logic              rsp_valid_q;
  sha512_pkg::t_word rsp_data_q;
  sha512_pkg::t_word rd_data;

  logic wr_en;
  logic rd_en;
  logic ctrl_wr;

  assign wr_en   = mmio_req.valid && mmio_req.write;
  assign rd_en   = mmio_req.valid && !mmio_req.write;
  assign ctrl_wr = wr_en && (mmio_req.idx == `SHA512_REG_CTRL);

  // ====================================================================
  // Register writes
  // ====================================================================
  always_ff @(posedge clk)
  begin
    if (wr_en && mmio_req.idx == `SHA512_REG_DSM)
      dsm_q <= mmio_req.data[`SHA512_ADDR_W-1:0];
    if (wr_en && mmio_req.idx == `SHA512_REG_SRC)
      src_q <= mmio_req.data[`SHA512_ADDR_W-1:0];
    if (wr_en && mmio_req.idx == `SHA512_REG_LEN)
      len_q <= mmio_req.data[`SHA512_LEN_W-1:0];
  end

  // Start is a one-cycle pulse, done stays set until the next CTRL write
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      start_q     <= 1'b0;
      done_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end
    else
    begin
      start_q     <= ctrl_wr && mmio_req.data[0];
      rsp_valid_q <= rd_en;
      if (ctrl_wr)
        done_q <= 1'b0;
      else if (job_done)
        done_q <= 1'b1;
    end
  end

  // ====================================================================
  // Register reads
  // ====================================================================

  // CTRL is write-only and reads as zero like any unused index
  always_comb
  begin
    case (mmio_req.idx)
      `SHA512_REG_DSM:  rd_data = sha512_pkg::t_word'(dsm_q);
      `SHA512_REG_SRC:  rd_data = sha512_pkg::t_word'(src_q);
      `SHA512_REG_LEN:  rd_data = sha512_pkg::t_word'(len_q);
      `SHA512_REG_STAT: rd_data = sha512_pkg::t_word'(done_q);
      default:          rd_data = '0;
    endcase
  end

  // Read data is registered, so a response follows its request by one cycle
  always_ff @(posedge clk)
  begin
    rsp_data_q <= rd_data;
  end

  assign mmio_rsp.valid = rsp_valid_q;
  assign mmio_rsp.data  = rsp_data_q;

  assign ctrl.start = start_q;
  assign ctrl.dsm   = dsm_q;
  assign ctrl.src   = src_q;
  assign ctrl.len   = len_q;

  // The host must not issue CTRL starts on back-to-back cycles
  a_start_single: assert property (@(posedge clk) disable iff (!arst_n)
    start_q |=> !start_q);

endmodule

// File: hdl/sha512_pkg.sv
`include "sha512_cfg.svh"

package sha512_pkg;

  // ====================================================================
  // Plain vector types
  // ====================================================================
  typedef logic [`SHA512_WORD_W-1:0] t_word;
  typedef logic [`SHA512_ADDR_W-1:0] t_addr;
  typedef logic [`SHA512_LEN_W-1:0]  t_len;
  typedef logic [2:0]                t_reg_idx;

  // ====================================================================
  // Host channel structs
  // ====================================================================

  // MMIO access from the host, a read when write is low
  typedef struct packed {
    logic     valid;
    logic     write;
    t_reg_idx idx;
    t_word    data;
  } t_mmio_req;

  // MMIO read data returned to the host
  typedef struct packed {
    logic  valid;
    t_word data;
  } t_mmio_rsp;

  typedef struct packed {
    logic  valid;
    t_addr addr;
  } t_rd_req;

  typedef struct packed {
    logic  valid;
    t_word data;
  } t_rd_rsp;

  typedef struct packed {
    logic  valid;
    t_addr addr;
    t_word data;
  } t_wr_req;

  // Everything the host sends, credits arrive as single-cycle pulses
  typedef struct packed {
    t_mmio_req mmio_req;
    t_rd_rsp   rd_rsp;
    logic      rd_credit;
    logic      wr_credit;
  } t_host_rx;

  typedef struct packed {
    t_mmio_rsp mmio_rsp;
    t_rd_req   rd_req;
    t_wr_req   wr_req;
  } t_host_tx;

  // Job setup from the register block to the requestor
  typedef struct packed {
    logic  start;
    t_addr dsm;
    t_addr src;
    t_len  len;
  } t_ctrl;

  typedef enum logic [2:0] {IDLE, FETCH, DRAIN, WRITE, DONE} t_req_state;

endpackage

// File: hdl/sha512_requestor.sv
`timescale 1ns/1ps
`include "sha512_cfg.svh"

module sha512_requestor
(
  input  logic                clk,
  input  logic                arst_n,
  input  sha512_pkg::t_ctrl   ctrl,
  input  sha512_pkg::t_rd_rsp rd_rsp,
  input  logic                rd_credit,
  input  logic                wr_credit,
  output sha512_pkg::t_rd_req rd_req,
  output sha512_pkg::t_wr_req wr_req,
  output logic                fold_clear,
  output logic                fold_valid,
  output sha512_pkg::t_word   fold_word,
  input  sha512_pkg::t_word   digest,
  output logic                job_done
);

  // Counter widths large enough to hold the full credit pools
  localparam int RD_CW = $clog2(`SHA512_RD_CREDITS + 1);
  localparam int WR_CW = $clog2(`SHA512_WR_CREDITS + 1);

  sha512_pkg::t_req_state state_q;
  logic [RD_CW-1:0]       rd_cnt_q;
  logic [WR_CW-1:0]       wr_cnt_q;
  sha512_pkg::t_len       issued_q;
  sha512_pkg::t_len       rcvd_q;

  // Job parameters captured when the job is accepted
  sha512_pkg::t_len  job_len_q;
  sha512_pkg::t_addr job_dsm_q;
  sha512_pkg::t_addr next_addr_q;

  logic              rd_valid_q;
  sha512_pkg::t_addr rd_addr_q;
  logic              wr_valid_q;
  sha512_pkg::t_word wr_data_q;
  logic              fold_clear_q;
  logic              fold_valid_q;
  sha512_pkg::t_word fold_word_q;

  logic take_job;
  logic issue_rd;
  logic issue_wr;

  assign take_job = (state_q == sha512_pkg::IDLE) && ctrl.start;

  // A read goes out only while a credit is held and words remain
  assign issue_rd = (state_q == sha512_pkg::FETCH) && (issued_q != job_len_q) &&
                    (rd_cnt_q != '0);

  // The digest write waits until no clear or fold update is still in flight
  assign issue_wr = (state_q == sha512_pkg::WRITE) && (wr_cnt_q != '0) &&
                    !fold_clear_q && !fold_valid_q;

  // ====================================================================
  // Credit counters
  // ====================================================================
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_cnt_q <= RD_CW'(`SHA512_RD_CREDITS);
      wr_cnt_q <= WR_CW'(`SHA512_WR_CREDITS);
    end
    else
    begin
      rd_cnt_q <= rd_cnt_q - RD_CW'(issue_rd) + RD_CW'(rd_credit);
      wr_cnt_q <= wr_cnt_q - WR_CW'(issue_wr) + WR_CW'(wr_credit);
    end
  end

  // ====================================================================
  // Job FSM
  // ====================================================================
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q      <= sha512_pkg::IDLE;
      issued_q     <= '0;
      rcvd_q       <= '0;
      rd_valid_q   <= 1'b0;
      wr_valid_q   <= 1'b0;
      fold_clear_q <= 1'b0;
      fold_valid_q <= 1'b0;
    end
    else
    begin
      rd_valid_q   <= issue_rd;
      wr_valid_q   <= issue_wr;
      fold_clear_q <= take_job;
      // Responses come back in order, so each one is folded as it lands
      fold_valid_q <= rd_rsp.valid;
      if (take_job)
      begin
        issued_q <= '0;
        rcvd_q   <= '0;
      end
      else
      begin
        if (issue_rd)
          issued_q <= issued_q + 1'b1;
        if (rd_rsp.valid)
          rcvd_q <= rcvd_q + 1'b1;
      end
      case (state_q)
        sha512_pkg::IDLE:
          if (ctrl.start)
            state_q <= (ctrl.len == '0) ? sha512_pkg::WRITE : sha512_pkg::FETCH;
        sha512_pkg::FETCH:
          if (issued_q == job_len_q)
            state_q <= sha512_pkg::DRAIN;
        sha512_pkg::DRAIN:
          if (rcvd_q == job_len_q)
            state_q <= sha512_pkg::WRITE;
        sha512_pkg::WRITE:
          if (issue_wr)
            state_q <= sha512_pkg::DONE;
        default:
          state_q <= sha512_pkg::IDLE;
      endcase
    end
  end

  // Addresses and data words
  always_ff @(posedge clk)
  begin
    fold_word_q <= rd_rsp.data;
    if (take_job)
    begin
      next_addr_q <= ctrl.src;
      job_len_q   <= ctrl.len;
      job_dsm_q   <= ctrl.dsm;
    end
    else if (issue_rd)
      next_addr_q <= next_addr_q + 1'b1;
    if (issue_rd)
      rd_addr_q <= next_addr_q;
    if (issue_wr)
      wr_data_q <= digest;
  end

  assign rd_req.valid = rd_valid_q;
  assign rd_req.addr  = rd_addr_q;
  assign wr_req.valid = wr_valid_q;
  assign wr_req.addr  = job_dsm_q;
  assign wr_req.data  = wr_data_q;
  assign fold_clear   = fold_clear_q;
  assign fold_valid   = fold_valid_q;
  assign fold_word    = fold_word_q;
  assign job_done     = (state_q == sha512_pkg::DONE);

  // A wrapped counter reads above the pool size, so one bound covers both ends
  a_rd_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
    rd_cnt_q <= RD_CW'(`SHA512_RD_CREDITS));
  a_wr_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
    wr_cnt_q <= WR_CW'(`SHA512_WR_CREDITS));

endmodule

// File: hdl/sha512_sigma_fold.sv
`timescale 1ns/1ps
`include "sha512_cfg.svh"

module sha512_sigma_fold
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              clear,
  input  logic              valid,
  input  sha512_pkg::t_word word,
  output sha512_pkg::t_word digest
);

  sha512_pkg::t_word digest_q;

  function automatic sha512_pkg::t_word rotr(input sha512_pkg::t_word x, input int n);
    return (x >> n) | (x << (`SHA512_WORD_W - n));
  endfunction

  // Small sigma0 of SHA-512, applied to the incoming word
  function automatic sha512_pkg::t_word sigma0(input sha512_pkg::t_word x);
    return rotr(x, 1) ^ rotr(x, 8) ^ (x >> 7);
  endfunction

  // Small sigma1, applied to the running digest
  function automatic sha512_pkg::t_word sigma1(input sha512_pkg::t_word x);
    return rotr(x, 19) ^ rotr(x, 61) ^ (x >> 6);
  endfunction

  // Clear wins over a word arriving on the same cycle, sums wrap at 2^64
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      digest_q <= `SHA512_IV;
    else if (clear)
      digest_q <= `SHA512_IV;
    else if (valid)
      digest_q <= sigma1(digest_q) + sigma0(word) + word;
  end

  assign digest = digest_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module sha512_afu_tb \
  -f sha512_afu.f \
  -o sim_sha512_afu

./obj_dir/sim_sha512_afu | tee sim.log

# The run passes only if the testbench printed its pass line.
if grep -q "^Finished with no errors$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// File: sha512_afu.f
+incdir+hdl
hdl/sha512_pkg.sv
hdl/sha512_csr.sv
hdl/sha512_requestor.sv
hdl/sha512_sigma_fold.sv
hdl/sha512_afu.sv
verif/sha512_afu_tb.sv

// File: verif/sha512_afu_tb.sv
`timescale 1ns/1ps
`include "sha512_cfg.svh"

module sha512_afu_tb;

  // ====================================================================
  // Test sizes and run limit
  // ====================================================================
  localparam int N_JOBS  = 6;
  localparam int MAX_LEN = 20;
  // Up to 8 cycles per word while credits are held back, plus room for MMIO traffic
  localparam int TIMEOUT_CYCLES = N_JOBS * MAX_LEN * 8 + 3000;

  logic                 clk;
  logic                 arst_n;
  sha512_pkg::t_host_rx host_rx;
  sha512_pkg::t_host_tx host_tx;

  // Each host channel has its own driver
  sha512_pkg::t_mmio_req mmio_drv;
  sha512_pkg::t_rd_rsp   rsp_drv;
  logic                  rd_credit_drv;
  logic                  wr_credit_drv;

  // Field order matches the packed struct, mmio_req is the top slice
  assign host_rx = {mmio_drv, rsp_drv, rd_credit_drv, wr_credit_drv};

  // Host memory, 256 random words that are also mixed with the full address
  sha512_pkg::t_word mem [0:255];
  logic [31:0]       rng_main;
  logic [31:0]       rng_mem;
  int                errors;
  int                cycles;

  // Bookkeeping of the memory model
  int                rd_total;
  int                wr_total;
  int                rd_owed;
  int                wr_owed;
  int                hold;
  int                now;
  int                last_due;
  sha512_pkg::t_addr pend_addr [$];
  int                pend_due [$];
  sha512_pkg::t_addr wr_addr_last;
  sha512_pkg::t_word wr_data_last;

  // Current job's source address and the read count when it started
  sha512_pkg::t_addr job_src;
  int                rd_base;

  sha512_afu UUT
  (
    .clk     (clk),
    .arst_n  (arst_n),
    .host_rx (host_rx),
    .host_tx (host_tx)
  );

  // ====================================================================
  // Helpers
  // ====================================================================
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // The address itself is xored in, so every address bit affects the word
  function automatic sha512_pkg::t_word mem_word(input sha512_pkg::t_addr a);
    return mem[a[7:0]] ^ {a, ~a};
  endfunction

  // One fold step: sigma1 of the digest, plus sigma0 of the word, plus the word
  function automatic sha512_pkg::t_word fold_ref(input sha512_pkg::t_word d,
                                                 input sha512_pkg::t_word w);
    sha512_pkg::t_word s0;
    sha512_pkg::t_word s1;
    s0 = {w[0], w[63:1]} ^ {w[7:0], w[63:8]} ^ {7'd0, w[63:7]};
    s1 = {d[18:0], d[63:19]} ^ {d[60:0], d[63:61]} ^ {6'd0, d[63:6]};
    return s1 + s0 + w;
  endfunction

  task automatic check_word(input string name, input sha512_pkg::t_word got,
                            input sha512_pkg::t_word exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input sha512_pkg::t_addr got,
                            input sha512_pkg::t_addr exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Both MMIO tasks start on a falling edge and return on one
  task automatic mmio_write(input sha512_pkg::t_reg_idx idx, input sha512_pkg::t_word data);
    mmio_drv.valid = 1'b1;
    mmio_drv.write = 1'b1;
    mmio_drv.idx   = idx;
    mmio_drv.data  = data;
    @(negedge clk);
    mmio_drv = '0;
  endtask

  // The response is due exactly two cycles after the request sits on the pins
  task automatic mmio_read(input sha512_pkg::t_reg_idx idx, output sha512_pkg::t_word data);
    mmio_drv.valid = 1'b1;
    mmio_drv.write = 1'b0;
    mmio_drv.idx   = idx;
    mmio_drv.data  = '0;
    @(negedge clk);
    mmio_drv = '0;
    @(negedge clk);
    if (!host_tx.mmio_rsp.valid)
    begin
      $display("%0t: MMIO read of register %0d got no response two cycles later",
               $time, idx);
      errors++;
    end
    data = host_tx.mmio_rsp.data;
  endtask

  // ====================================================================
  // Clock and timeout
  // ====================================================================
  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run hung and did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // ====================================================================
  // Host memory model
  // ====================================================================

  // Outputs are read on the falling edge, where they are stable
  always @(negedge clk)
  begin : host_memory
    logic [31:0] r;
    int          due;
    if (arst_n)
    begin
      rsp_drv       = '0;
      rd_credit_drv = 1'b0;
      wr_credit_drv = 1'b0;
      // Reads must walk the source buffer one word at a time
      if (host_tx.rd_req.valid)
      begin
        check_addr("rd_req.addr", host_tx.rd_req.addr,
                   job_src + sha512_pkg::t_addr'(rd_total - rd_base));
        rd_total++;
        rd_owed++;
        rng_mem = xorshift(rng_mem);
        due = now + 1 + int'(rng_mem % 4);
        // Never overtake an earlier response
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        pend_addr.push_back(host_tx.rd_req.addr);
        pend_due.push_back(due);
      end
      if (host_tx.wr_req.valid)
      begin
        wr_addr_last = host_tx.wr_req.addr;
        wr_data_last = host_tx.wr_req.data;
        wr_total++;
        wr_owed++;
      end
      // A request whose credit has not come back yet counts as outstanding
      if (rd_owed > `SHA512_RD_CREDITS || wr_owed > `SHA512_WR_CREDITS)
      begin
        $display("%0t: more requests outstanding than credits allow (%0d reads, %0d writes)",
                 $time, rd_owed, wr_owed);
        errors++;
      end
      if (pend_due.size() > 0 && pend_due[0] == now)
      begin
        rsp_drv.valid = 1'b1;
        rsp_drv.data  = mem_word(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      // Credits trickle back, with stretches of 8 to 23 cycles where none return
      rng_mem = xorshift(rng_mem);
      r = rng_mem;
      if (hold > 0)
        hold--;
      else if (r[4:0] == 5'd0)
        hold = 8 + int'(r[11:8]);
      else
      begin
        if (rd_owed > 0 && r[12])
        begin
          rd_credit_drv = 1'b1;
          rd_owed--;
        end
        if (wr_owed > 0 && r[13])
        begin
          wr_credit_drv = 1'b1;
          wr_owed--;
        end
      end
      now++;
    end
  end

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial
  begin
    sha512_pkg::t_word rdata;
    sha512_pkg::t_word exp_digest;
    sha512_pkg::t_word val;
    sha512_pkg::t_addr src;
    sha512_pkg::t_addr dsm;
    sha512_pkg::t_len  len;
    logic              done_seen;
    int                polls;
    int                wr_base;
    arst_n        = 1'b0;
    mmio_drv      = '0;
    rsp_drv       = '0;
    rd_credit_drv = 1'b0;
    wr_credit_drv = 1'b0;
    errors        = 0;
    cycles        = 0;
    rd_total      = 0;
    wr_total      = 0;
    rd_owed       = 0;
    wr_owed       = 0;
    hold          = 0;
    now           = 0;
    last_due      = 0;
    job_src       = '0;
    rd_base       = 0;
    rng_main      = 32'he205;
    rng_mem       = 32'he205 ^ 32'h5a5a_5a5a;
    for (int i = 0; i < 256; i++)
    begin
      rng_main  = xorshift(rng_main);
      val[63:32] = rng_main;
      rng_main  = xorshift(rng_main);
      val[31:0] = rng_main;
      mem[i]    = val;
    end
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // Register readback, each register keeps only its own width
    rng_main = xorshift(rng_main);
    dsm      = rng_main;
    rng_main = xorshift(rng_main);
    src      = rng_main;
    rng_main = xorshift(rng_main);
    len      = rng_main[15:0];
    mmio_write(`SHA512_REG_DSM, {32'd0, dsm});
    mmio_write(`SHA512_REG_SRC, {32'd0, src});
    mmio_write(`SHA512_REG_LEN, {48'd0, len});
    mmio_read(`SHA512_REG_DSM, rdata);
    check_word("mmio_rsp.data DSM", rdata, {32'd0, dsm});
    mmio_read(`SHA512_REG_SRC, rdata);
    check_word("mmio_rsp.data SRC", rdata, {32'd0, src});
    mmio_read(`SHA512_REG_LEN, rdata);
    check_word("mmio_rsp.data LEN", rdata, {48'd0, len});

    // Jobs, the first one with an empty buffer
    for (int job = 0; job < N_JOBS; job++)
    begin
      rng_main = xorshift(rng_main);
      len      = (job == 0) ? '0 : sha512_pkg::t_len'(rng_main % (MAX_LEN + 1));
      rng_main = xorshift(rng_main);
      src      = rng_main;
      rng_main = xorshift(rng_main);
      dsm      = rng_main;
      exp_digest = `SHA512_IV;
      for (int i = 0; i < int'(len); i++)
        exp_digest = fold_ref(exp_digest, mem_word(src + sha512_pkg::t_addr'(i)));
      job_src = src;
      rd_base = rd_total;
      wr_base = wr_total;
      mmio_write(`SHA512_REG_DSM, {32'd0, dsm});
      mmio_write(`SHA512_REG_SRC, {32'd0, src});
      mmio_write(`SHA512_REG_LEN, {48'd0, len});
      mmio_write(`SHA512_REG_CTRL, 64'd1);
      // The digest write marks the end of the job
      while (wr_total == wr_base)
        @(negedge clk);
      check_addr("wr_req.addr", wr_addr_last, dsm);
      check_word("wr_req.data", wr_data_last, exp_digest);
      if (rd_total - rd_base != int'(len))
      begin
        $display("%0t: job %0d sent %0d reads for a buffer of %0d words",
                 $time, job, rd_total - rd_base, len);
        errors++;
      end
      // Done reaches STAT a few cycles after the write
      done_seen = 1'b0;
      polls     = 0;
      while (!done_seen && polls < 8)
      begin
        mmio_read(`SHA512_REG_STAT, rdata);
        done_seen = rdata[0];
        polls++;
      end
      check_word("mmio_rsp.data STAT after job", rdata, 64'd1);
      mmio_write(`SHA512_REG_CTRL, 64'd0);
      mmio_read(`SHA512_REG_STAT, rdata);
      check_word("mmio_rsp.data STAT after CTRL", rdata, 64'd0);
    end

    $display("Run complete: %0d jobs, %0d reads, %0d errors", N_JOBS, rd_total, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
